// ==== hdl/core_pkg.sv ====
/* Core package: shared widths, opcode and ALU enums, run states
   and the APB register map of the rv_core host port */
package core_pkg;

  localparam int xlen = 32;
  localparam int reg_count = 8;

  typedef logic [xlen-1:0] word_t;
  typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

  // RV32I major opcodes handled by the core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    SYSTEM = 7'b1110011
  } opcode_e;

  // PASS_NONE marks an operation that writes nothing
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    PASS_NONE
  } alu_op_e;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } run_state_e;

  // APB register map
  localparam logic [11:0] ADDR_IMEM_BASE = 12'h000;
  localparam logic [11:0] ADDR_CTRL      = 12'h100;
  localparam logic [11:0] ADDR_STATUS    = 12'h104;
  localparam logic [11:0] ADDR_RETIRED   = 12'h108;
  localparam logic [11:0] ADDR_REG_BASE  = 12'h200;

  // ECALL only, EBREAK and other SYSTEM words fall through as NOPs
  function automatic logic is_ecall(word_t instr);
    return (instr[6:0] == SYSTEM) && (instr[14:12] == 3'b000) && (instr[31:20] == 12'h000);
  endfunction

endpackage

// ==== hdl/issue_if.sv ====
/* Issue interface: one decoded operation with its operands,
   handed from decode to writeback */
`timescale 1ns/1ps

interface issue_if;
  import core_pkg::*;

  logic     valid;
  alu_op_e  op;
  reg_idx_t rd;
  word_t    opa;
  word_t    opb;
  logic     halt;

  modport issue (output valid, op, rd, opa, opb, halt);
  modport exec  (input valid, op, rd, opa, opb, halt);

endinterface

// ==== hdl/rf_read_if.sv ====
/* Register file read interface: two combinational read ports */
`timescale 1ns/1ps

interface rf_read_if;
  import core_pkg::*;

  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rdata1;
  word_t    rdata2;

  // Decode asks, writeback answers in the same cycle
  modport req  (output rs1, rs2, input rdata1, rdata2);
  modport resp (input rs1, rs2, output rdata1, rdata2);

endinterface

// ==== hdl/apb_host_port.sv ====
/* APB host port: address decode, program memory writes, start and
   sticky done status, retired count and register readback */
`timescale 1ns/1ps

module apb_host_port #(
  parameter int IMEM_DEPTH = 16
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [11:0]                   paddr,
  input  core_pkg::word_t               pwdata,
  output core_pkg::word_t               prdata,
  output logic                          pready,
  output logic                          pslverr,
  output logic                          imem_we,
  output logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
  output core_pkg::word_t               imem_wdata,
  output logic                          start,
  input  logic                          busy,
  input  core_pkg::word_t               retired,
  output core_pkg::reg_idx_t            dbg_idx,
  input  core_pkg::word_t               dbg_data
);
  import core_pkg::*;

  localparam int AW = $clog2(IMEM_DEPTH);

  logic access;
  logic aligned;
  logic hit_imem, hit_ctrl, hit_status, hit_retired, hit_reg;
  logic mapped, read_only, err;
  logic busy_q, done;

  assign access  = psel && penable;
  assign aligned = (paddr[1:0] == 2'b00);

  assign hit_imem    = aligned && (paddr[11:AW+2] == ADDR_IMEM_BASE[11:AW+2]);
  assign hit_ctrl    = (paddr == ADDR_CTRL);
  assign hit_status  = (paddr == ADDR_STATUS);
  assign hit_retired = (paddr == ADDR_RETIRED);
  assign hit_reg     = aligned && (paddr[11:5] == ADDR_REG_BASE[11:5]);

  assign mapped    = hit_imem || hit_ctrl || hit_status || hit_retired || hit_reg;
  assign read_only = hit_status || hit_retired || hit_reg;

  // Program memory is locked while the core runs
  assign err = !mapped || (pwrite && read_only) || (pwrite && hit_imem && busy);

  assign pready  = 1'b1;
  assign pslverr = access && err;

  assign imem_we    = access && pwrite && hit_imem && !err;
  assign imem_addr  = paddr[AW+1:2];
  assign imem_wdata = pwdata;

  // Start while busy is dropped silently
  assign start = access && pwrite && hit_ctrl && pwdata[0] && !busy;

  assign dbg_idx = paddr[4:2];

  always_comb
  begin
    prdata = '0;
    if (access && !pwrite)
    begin
      if (hit_status)
        prdata = {{(xlen-2){1'b0}}, done, busy};
      else if (hit_retired)
        prdata = retired;
      else if (hit_reg)
        prdata = dbg_data;
    end
  end

  // Done sets once busy has dropped, start clears it
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy_q <= 1'b0;
      done   <= 1'b0;
    end
    else
    begin
      busy_q <= busy;
      if (start)
        done <= 1'b0;
      else if (busy_q && !busy)
        done <= 1'b1;
    end
  end

endmodule

// ==== hdl/fetch_unit.sv ====
/* Fetch stage: instruction store, PC, run state machine and
   the fetch register feeding decode */
`timescale 1ns/1ps

module fetch_unit #(
  parameter int IMEM_DEPTH = 16
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
  input  core_pkg::word_t               imem_wdata,
  input  logic                          start,
  output logic                          busy,
  input  logic                          halt_retired,
  input  logic                          stall,
  output logic                          f_valid,
  output core_pkg::word_t               f_instr
);
  import core_pkg::*;

  localparam int AW = $clog2(IMEM_DEPTH);

  word_t            imem [IMEM_DEPTH];
  logic [AW-1:0]    pc;
  run_state_e       state;
  logic             fetch_en;

  always_ff @(posedge clk)
  begin
    if (imem_we)
      imem[imem_addr] <= imem_wdata;
  end

  assign busy     = (state != IDLE);
  assign fetch_en = (state == RUN) && !stall;

  // PC wraps at the end of the store
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= IDLE;
      pc      <= '0;
      f_valid <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          f_valid <= 1'b0;
          if (start)
          begin
            pc    <= '0;
            state <= RUN;
          end
        end
        RUN:
        begin
          if (!stall)
          begin
            f_valid <= 1'b1;
            pc      <= pc + 1'b1;
            if (is_ecall(imem[pc]))
              state <= DRAIN;
          end
        end
        DRAIN:
        begin
          // Last word leaves once decode takes it
          if (!stall)
            f_valid <= 1'b0;
          if (halt_retired)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (fetch_en)
      f_instr <= imem[pc];
  end

endmodule

// ==== hdl/decode_unit.sv ====
/* Decode stage: instruction decode, register read, RAW hazard
   stall and the issue register towards writeback */
`timescale 1ns/1ps

module decode_unit (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            f_valid,
  input  core_pkg::word_t f_instr,
  output logic            stall,
  rf_read_if.req          rf,
  issue_if.issue          iss
);
  import core_pkg::*;

  opcode_e   opc;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_op_e   dec_op;
  logic      use_rs1;
  logic      use_rs2;
  logic      use_imm;
  word_t     imm;
  logic      inflight_wr;
  logic      hazard;
  logic      take;

  assign opc    = opcode_e'(f_instr[6:0]);
  assign funct3 = f_instr[14:12];
  assign funct7 = f_instr[31:25];
  assign imm    = {{(xlen-12){f_instr[31]}}, f_instr[31:20]};

  // Only the low index bits matter with eight registers
  assign rf.rs1 = f_instr[17:15];
  assign rf.rs2 = f_instr[22:20];

  always_comb
  begin
    dec_op  = PASS_NONE;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_imm = 1'b0;
    case (opc)
      OP:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct3)
          3'b000:
          begin
            if (funct7 == 7'b0000000)
              dec_op = ADD;
            else if (funct7 == 7'b0100000)
              dec_op = SUB;
          end
          3'b100: dec_op = (funct7 == 7'b0) ? XOR : PASS_NONE;
          3'b110: dec_op = (funct7 == 7'b0) ? OR : PASS_NONE;
          3'b111: dec_op = (funct7 == 7'b0) ? AND : PASS_NONE;
          default: dec_op = PASS_NONE;
        endcase
      end
      OP_IMM:
      begin
        // ADDI only, other immediates become NOPs
        if (funct3 == 3'b000)
        begin
          dec_op  = ADD;
          use_rs1 = 1'b1;
          use_imm = 1'b1;
        end
      end
      default: dec_op = PASS_NONE;
    endcase
  end

  // No forwarding, so wait until the producer has been written back
  assign inflight_wr = iss.valid && (iss.op != PASS_NONE) && (iss.rd != '0);
  assign hazard      = inflight_wr && ((use_rs1 && (rf.rs1 == iss.rd)) ||
                                       (use_rs2 && (rf.rs2 == iss.rd)));
  assign stall       = f_valid && hazard;
  assign take        = f_valid && !stall;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      iss.valid <= 1'b0;
    else
      iss.valid <= take;
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      iss.op   <= dec_op;
      iss.rd   <= f_instr[9:7];
      iss.opa  <= rf.rdata1;
      iss.opb  <= use_imm ? imm : rf.rdata2;
      iss.halt <= is_ecall(f_instr);
    end
  end

endmodule

// ==== hdl/writeback_unit.sv ====
/* Writeback stage: ALU, eight-entry register file with debug read
   port, retired-instruction counter and halt detection */
`timescale 1ns/1ps

module writeback_unit (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               start,
  issue_if.exec              iss,
  rf_read_if.resp            rf,
  input  core_pkg::reg_idx_t dbg_idx,
  output core_pkg::word_t    dbg_data,
  output core_pkg::word_t    retired,
  output logic               halt_retired
);
  import core_pkg::*;

  word_t regs [reg_count];
  word_t alu_res;
  logic  retire;

  function automatic word_t rf_read(reg_idx_t idx);
    return (idx == '0) ? '0 : regs[idx];
  endfunction

  always_comb
  begin
    case (iss.op)
      ADD:     alu_res = iss.opa + iss.opb;
      SUB:     alu_res = iss.opa - iss.opb;
      AND:     alu_res = iss.opa & iss.opb;
      OR:      alu_res = iss.opa | iss.opb;
      XOR:     alu_res = iss.opa ^ iss.opb;
      default: alu_res = '0;
    endcase
  end

  // ECALL and NOPs carry PASS_NONE and are not counted
  assign retire = iss.valid && (iss.op != PASS_NONE);

  always_comb
  begin
    rf.rdata1 = rf_read(rf.rs1);
    rf.rdata2 = rf_read(rf.rs2);
    dbg_data  = rf_read(dbg_idx);
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < reg_count; i++)
        regs[i] <= '0;
      retired      <= '0;
      halt_retired <= 1'b0;
    end
    else
    begin
      halt_retired <= iss.valid && iss.halt;
      if (start)
        retired <= '0;
      else if (retire)
        retired <= retired + 1'b1;
      // x0 is never written
      if (retire && (iss.rd != '0))
        regs[iss.rd] <= alu_res;
    end
  end

endmodule

// ==== hdl/rv_core_top.sv ====
/* rv_core top level: APB host port and the three pipeline stages */
`timescale 1ns/1ps

module rv_core_top #(
  parameter int IMEM_DEPTH = 16
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  logic [11:0]     paddr,
  input  core_pkg::word_t pwdata,
  output core_pkg::word_t prdata,
  output logic            pready,
  output logic            pslverr
);
  import core_pkg::*;

  logic                          imem_we;
  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr;
  word_t                         imem_wdata;
  logic                          start;
  logic                          busy;
  word_t                         retired;
  reg_idx_t                      dbg_idx;
  word_t                         dbg_data;
  logic                          halt_retired;
  logic                          stall;
  logic                          f_valid;
  word_t                         f_instr;

  issue_if   iss ();
  rf_read_if rf ();

  apb_host_port #(.IMEM_DEPTH(IMEM_DEPTH)) u_host (
    .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .imem_we, .imem_addr, .imem_wdata, .start, .busy,
    .retired, .dbg_idx, .dbg_data
  );

  fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
    .clk, .arst_n, .imem_we, .imem_addr, .imem_wdata, .start, .busy,
    .halt_retired, .stall, .f_valid, .f_instr
  );

  decode_unit u_decode (
    .clk, .arst_n, .f_valid, .f_instr, .stall, .rf(rf.req), .iss(iss.issue)
  );

  writeback_unit u_wb (
    .clk, .arst_n, .start, .iss(iss.exec), .rf(rf.resp),
    .dbg_idx, .dbg_data, .retired, .halt_retired
  );

endmodule

// ==== bench/core_chk.sv ====
/* APB and core protocol assertions bound into rv_core_top */
`timescale 1ns/1ps

module core_chk (
  input logic            clk,
  input logic            arst_n,
  input logic            psel,
  input logic            penable,
  input logic            pwrite,
  input logic [11:0]     paddr,
  input core_pkg::word_t prdata,
  input logic            pready,
  input logic            pslverr,
  input logic            busy
);
  import core_pkg::*;

  logic ctrl_write;
  int   fail_count = 0;

  assign ctrl_write = psel && penable && pwrite && (paddr == ADDR_CTRL);

  // Zero wait states
  pready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
    penable |-> pready)
    else
    begin
      fail_count++;
      $error("pready low while penable is high");
    end

  pslverr_in_access: assert property (@(posedge clk) disable iff (!arst_n)
    pslverr |-> (psel && penable))
    else
    begin
      fail_count++;
      $error("pslverr outside an access phase");
    end

  x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n)
    (psel && penable && !pwrite && (paddr == ADDR_REG_BASE)) |-> (prdata == '0))
    else
    begin
      fail_count++;
      $error("x0 readback is not zero");
    end

  // Busy rises on the edge that ends the CTRL write
  busy_after_start: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(busy) |-> $past(ctrl_write))
    else
    begin
      fail_count++;
      $error("busy rose without a CTRL write");
    end

endmodule

bind rv_core_top core_chk u_chk (
  .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .prdata, .pready, .pslverr, .busy
);

// ==== bench/core_tb.sv ====
/* Testbench for rv_core with clock and reset source, APB driver replaying
   the stimulus file, random idle gaps, readback checks and watchdog */
`timescale 1ns/1ps

module core_clk_gen #(
  parameter int PERIOD = 100
) (
  output logic clk,
  output logic arst_n
);
  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Two cycles of reset ending on a falling edge
  initial
  begin
    arst_n = 1'b0;
    #(2 * PERIOD);
    arst_n = 1'b1;
  end
endmodule

module core_tb;
  import core_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int CYCLES_PER_LINE = 64;
  localparam int RESET_CYCLES    = 2;

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  word_t       pwdata;
  word_t       prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] lfsr = 32'hb507;
  int          errors = 0;
  int          checks = 0;
  bit          loaded = 1'b0;
  byte         cmd_q[$];
  logic [11:0] addr_q[$];
  word_t       data_q[$];

  core_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk, .arst_n);

  rv_core_top #(.IMEM_DEPTH(16)) UUT (
    .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // 0 to 3 idle cycles from two LFSR bits
  task automatic idle_gap();
    int n;
    n = 0;
    repeat (2)
    begin
      lfsr = lfsr_next(lfsr);
      n = n * 2 + int'(lfsr[0]);
    end
    repeat (n) @(negedge clk);
  endtask

  task automatic check_value(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input word_t wdata,
                          output word_t rdata, output logic err);
    idle_gap();
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    // Outputs are settled in the low half of the access cycle
    #(CLK_PERIOD / 4);
    rdata = prdata;
    err   = pslverr;
    check_value("pready", word_t'(pready), 32'd1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic run_line(input byte cmd, input logic [11:0] addr, input word_t data);
    word_t rdata;
    logic  err;
    string tag;
    tag = $sformatf("%c %h", cmd, addr);
    case (cmd)
      "W":
      begin
        apb_xfer(1'b1, addr, data, rdata, err);
        check_value({tag, " pslverr"}, word_t'(err), 32'd0);
      end
      "E":
      begin
        apb_xfer(1'b1, addr, data, rdata, err);
        check_value({tag, " pslverr"}, word_t'(err), 32'd1);
      end
      "R":
      begin
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_value({tag, " pslverr"}, word_t'(err), 32'd0);
        check_value(tag, rdata, data);
      end
      "S":
      begin
        apb_xfer(1'b1, ADDR_CTRL, 32'd1, rdata, err);
        check_value("start pslverr", word_t'(err), 32'd0);
        // Wait for the sticky done bit
        do
          apb_xfer(1'b0, ADDR_STATUS, '0, rdata, err);
        while (rdata[1] !== 1'b1);
      end
      default:
      begin
        errors++;
        $display("Unknown command '%c' in the stimulus file", cmd);
      end
    endcase
  endtask

  task automatic load_stimulus();
    int          fd;
    string       line;
    byte         c;
    logic [11:0] a;
    word_t       d;
    fd = $fopen("bench/core_stim.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open the stimulus file bench/core_stim.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        a    = '0;
        d    = '0;
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
        begin
          void'($sscanf(line, "%c %h %h", c, a, d));
          cmd_q.push_back(c);
          addr_q.push_back(a);
          data_q.push_back(d);
        end
      end
      $fclose(fd);
    end
  endtask

  initial
  begin
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    $timeformat(-9, 0, " ns", 0);
    load_stimulus();
    loaded = 1'b1;
    wait (arst_n === 1'b1);
    foreach (cmd_q[i])
      run_line(cmd_q[i], addr_q[i], data_q[i]);
    @(negedge clk);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, UUT.u_chk.fail_count);
    if (errors == 0 && UUT.u_chk.fail_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // Watchdog sized from the number of stimulus lines
  initial
  begin
    wait (loaded);
    #((cmd_q.size() * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: the stimulus did not complete within %0d cycles",
             cmd_q.size() * CYCLES_PER_LINE + RESET_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== bench/core_stim.txt ====
# Columns: command address(hex) data(hex); W write, E write expecting pslverr,
# R read and compare, S start and wait for done
R 104 00000000
W 000 12300093
W 004 FFB00113
W 008 00700013
W 00C 000000FF
W 010 002081B3
W 014 40118233
W 018 001242B3
W 01C 0022F333
W 020 0020E3B3
W 024 00000073
S
R 104 00000002
R 108 00000008
R 200 00000000
R 204 00000123
R 208 FFFFFFFB
R 20C 0000011E
R 210 FFFFFFFB
R 214 FFFFFED8
R 218 FFFFFED8
R 21C FFFFFFFB
E 240 00000001
E 104 00000003
E 204 00000055
R 104 00000002
R 204 00000123
W 100 00000001
E 000 7FF00093
S
S
R 204 00000123
R 108 00000008
W 000 00110113
W 004 00000073
S
R 104 00000002
R 108 00000001
R 208 FFFFFFFC
R 21C FFFFFFFB

// ==== vlog.f ====
hdl/core_pkg.sv
hdl/issue_if.sv
hdl/rf_read_if.sv
hdl/apb_host_port.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/writeback_unit.sv
hdl/rv_core_top.sv
bench/core_chk.sv
bench/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/core_pkg.sv
  - hdl/issue_if.sv
  - hdl/rf_read_if.sv
  - hdl/apb_host_port.sv
  - hdl/fetch_unit.sv
  - hdl/decode_unit.sv
  - hdl/writeback_unit.sv
  - hdl/rv_core_top.sv
  - target: simulation
    files:
      - bench/core_chk.sv
      - bench/core_tb.sv
